//--- src.f
hdl/cart_pkg.sv
hdl/snes_bus_if.sv
hdl/snes_strobe_filter.sv
hdl/snes_addr_map.sv
hdl/rom_arbiter.sv
hdl/cart_main.sv
dv/tb_cart_main.sv

//--- Bender.yml
package:
  name: cart_main

sources:
  - files:
      - hdl/cart_pkg.sv
      - hdl/snes_bus_if.sv
      - hdl/snes_strobe_filter.sv
      - hdl/snes_addr_map.sv
      - hdl/rom_arbiter.sv
      - hdl/cart_main.sv
  - target: test
    files:
      - dv/tb_cart_main.sv

//--- dv/tb_cart_main.sv
`timescale 1ns/1ps

module tb_cart_main;
  import cart_pkg::*;

  localparam logic [3:0]  ROM_CYCLE_LEN   = 4'd6;
  localparam logic [17:0] DEAD_TIMEOUT    = 18'd40;
  localparam int          HOLD            = 12;  // Cycles per console pin value
  localparam int          N_READS         = 16;
  localparam int          MAX_ACCESS_LEN  = 2 * HOLD + ROM_CYCLE_LEN + 2;
  localparam int          N_TXNS          = 2 * N_READS + 16;
  localparam int          WATCHDOG_CYCLES = N_TXNS * MAX_ACCESS_LEN * 20;
  localparam int          READY_LIMIT     = 4 * MAX_ACCESS_LEN;

  // Comparator select bits
  localparam logic [7:0] M_ADDR  = 8'b00000001;
  localparam logic [7:0] M_DATA  = 8'b00000010;
  localparam logic [7:0] M_OE    = 8'b00000100;
  localparam logic [7:0] M_WE    = 8'b00001000;
  localparam logic [7:0] M_WBYTE = 8'b00010000;
  localparam logic [7:0] M_RDY   = 8'b00100000;
  localparam logic [7:0] M_MCU   = 8'b01000000;
  localparam logic [7:0] M_DOE   = 8'b10000000;

  logic        CLK2;
  logic        rst_n;
  snes_addr_t  snes_addr;
  logic        snes_read_n;
  logic        snes_write_n;
  logic        snes_cpu_clk;
  logic        snes_romsel_n;
  logic [7:0]  snes_data;
  logic [7:0]  snes_data_out;
  logic        snes_data_oe;
  rom_addr_t   mcu_addr;
  logic [7:0]  mcu_wdata;
  logic        mcu_rrq;
  logic        mcu_wrq;
  logic [7:0]  mcu_rdata;
  logic        mcu_rdy;
  logic [15:0] rom_rdata;
  logic [15:0] rom_wdata;
  logic        rom_data_oe;
  logic [22:0] rom_addr;
  logic        rom_we;
  logic        rom_bhe;
  logic        rom_ble;
  mapper_e     mapper;
  rom_addr_t   rom_mask;
  rom_addr_t   saveram_mask;

  logic [15:0] mem [0:131071];  // ROM words, then save-RAM words from index 64K
  logic [7:0]  chk_mask;
  string       chk_name;
  rom_addr_t   exp_addr;
  logic [7:0]  exp_data;
  logic        exp_oe;
  logic        exp_we;
  logic [7:0]  exp_wbyte;
  logic        exp_rdy;
  logic [7:0]  exp_mcu;
  logic        exp_doe;
  integer      seed;
  bit          mcu_done;

  always #5 CLK2 = ~CLK2;

  cart_main #(
    .DEAD_TIMEOUT (DEAD_TIMEOUT)
  ) i_cart_main (
    .CLK2          (CLK2),
    .rst_n         (rst_n),
    .snes_addr     (snes_addr),
    .snes_read_n   (snes_read_n),
    .snes_write_n  (snes_write_n),
    .snes_cpu_clk  (snes_cpu_clk),
    .snes_romsel_n (snes_romsel_n),
    .snes_data     (snes_data),
    .snes_data_out (snes_data_out),
    .snes_data_oe  (snes_data_oe),
    .mcu_addr      (mcu_addr),
    .mcu_wdata     (mcu_wdata),
    .mcu_rrq       (mcu_rrq),
    .mcu_wrq       (mcu_wrq),
    .mcu_rdata     (mcu_rdata),
    .mcu_rdy       (mcu_rdy),
    .rom_rdata     (rom_rdata),
    .rom_wdata     (rom_wdata),
    .rom_data_oe   (rom_data_oe),
    .rom_addr      (rom_addr),
    .rom_we        (rom_we),
    .rom_bhe       (rom_bhe),
    .rom_ble       (rom_ble),
    .mapper        (mapper),
    .rom_mask      (rom_mask),
    .saveram_mask  (saveram_mask)
  );

  //////////////////////////////////////////////////////////////////////
  // Memory model
  //////////////////////////////////////////////////////////////////////

  function automatic logic [16:0] mem_index(input logic [22:0] w);
    return {w[22], w[15:0]};  // Save-RAM words sit above bit 22
  endfunction

  function automatic logic [15:0] fill_word(input logic [22:0] w);
    return {w[7:0] ^ w[22:15], w[15:8] ^ w[7:0]} ^ 16'ha55a;
  endfunction

  assign rom_rdata = mem[mem_index(rom_addr)];

  always @(posedge CLK2) begin
    if (rom_we === 1'b0) begin
      if (!rom_bhe) begin
        mem[mem_index(rom_addr)][15:8] <= rom_wdata[15:8];
      end
      if (!rom_ble) begin
        mem[mem_index(rom_addr)][7:0] <= rom_wdata[7:0];
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Reference mapping and checking
  //////////////////////////////////////////////////////////////////////

  // Returns {is_rom, is_writable, byte address}
  function automatic logic [25:0] expected_map(input snes_addr_t a, input mapper_e map,
                                               input rom_addr_t rmask, input rom_addr_t smask);
    logic [7:0] bank;
    logic       hit_rom;
    logic       hit_sram;
    rom_addr_t  addr;
    bank = a[23:16];
    if (map == MAP_LOROM) begin
      hit_rom  = a[15] && (bank != 8'h7e) && (bank != 8'h7f);
      hit_sram = !a[15] && (bank >= 8'h70) && (bank <= 8'h7d);
      if (hit_sram) begin
        addr = SAVERAM_BASE + ({5'b0, bank[3:0], a[14:0]} & smask);
      end else begin
        addr = {2'b0, bank[6:0], a[14:0]} & rmask;
      end
    end else begin
      hit_rom  = bank[6] || a[15];
      hit_sram = (bank[6:0] >= 7'h20) && (bank[6:0] <= 7'h3f)
                 && (a[15:0] >= 16'h6000) && (a[15:0] <= 16'h7fff);
      if (hit_sram) begin
        addr = SAVERAM_BASE + ({6'b0, bank[4:0], a[12:0]} & smask);
      end else begin
        addr = {2'b0, bank[5:0], a[15:0]} & rmask;
      end
    end
    return {hit_rom, hit_sram, addr};
  endfunction

  task automatic fail_stop(input string why);
    $display("*** TEST FAILED ***");
    $fatal(1, "%s", why);
  endtask

  task automatic expect_equal(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
    if (exp !== act) begin
      $display("error %s expected %0h actual %0h", name, exp, act);
      fail_stop("value mismatch");
    end
  endtask

  // Sees DUT outputs as they were just before the edge
  always @(posedge CLK2) begin
    if (|(chk_mask & M_ADDR)) begin
      expect_equal({chk_name, " address"}, exp_addr, {rom_addr, rom_bhe});
      expect_equal({chk_name, " low byte lane"}, !exp_addr[0], rom_ble);
    end
    if (|(chk_mask & M_DATA)) expect_equal({chk_name, " data"}, exp_data, snes_data_out);
    if (|(chk_mask & M_OE))   expect_equal({chk_name, " data oe"}, exp_oe, snes_data_oe);
    if (|(chk_mask & M_WE))   expect_equal({chk_name, " rom_we"}, exp_we, rom_we);
    if (|(chk_mask & M_WBYTE)) begin
      expect_equal({chk_name, " write byte"}, exp_wbyte,
                   rom_bhe ? rom_wdata[7:0] : rom_wdata[15:8]);
    end
    if (|(chk_mask & M_RDY))  expect_equal({chk_name, " mcu_rdy"}, exp_rdy, mcu_rdy);
    if (|(chk_mask & M_MCU))  expect_equal({chk_name, " mcu_rdata"}, exp_mcu, mcu_rdata);
    if (|(chk_mask & M_DOE))  expect_equal({chk_name, " rom_data_oe"}, exp_doe, rom_data_oe);
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus tasks, each starts and ends right after a rising edge
  //////////////////////////////////////////////////////////////////////

  task automatic console_read(input string name, input snes_addr_t a, input bit live,
                              input bit do_check);
    logic [25:0] m;
    logic [15:0] w;
    logic        romsel;
    m      = expected_map(a, mapper, rom_mask, saveram_mask);
    romsel = a[22] | a[15];  // Console ROM select decode
    snes_addr     <= a;
    snes_read_n   <= 1'b0;
    snes_romsel_n <= ~romsel;
    snes_cpu_clk  <= live;
    repeat (HOLD) @(posedge CLK2);
    if (do_check) begin
      w = mem[mem_index(m[23:1])];
      chk_name <= name;
      exp_addr <= m[23:0];
      exp_data <= m[0] ? w[7:0] : w[15:8];
      exp_oe   <= (m[25] & romsel) | m[24];
      exp_doe  <= 1'b0;  // Nothing drives the ROM bus on a read
      chk_mask <= M_ADDR | M_DATA | M_OE | M_DOE;
      @(posedge CLK2);
      chk_mask <= '0;
    end
    snes_read_n   <= 1'b1;
    snes_romsel_n <= 1'b1;
    snes_cpu_clk  <= 1'b0;
    repeat (HOLD) @(posedge CLK2);
  endtask

  task automatic console_write(input string name, input snes_addr_t a, input logic [7:0] d);
    logic [25:0] m;
    logic [15:0] w;
    logic [7:0]  keep;
    m    = expected_map(a, mapper, rom_mask, saveram_mask);
    w    = mem[mem_index(m[23:1])];
    keep = m[24] ? d : (m[0] ? w[7:0] : w[15:8]);  // ROM area must not change
    snes_addr     <= a;
    snes_cpu_clk  <= 1'b1;
    snes_romsel_n <= ~(a[22] | a[15]);
    repeat (HOLD) @(posedge CLK2);
    snes_write_n <= 1'b0;
    snes_data    <= d;
    repeat (HOLD) @(posedge CLK2);
    chk_name  <= name;
    exp_addr  <= m[23:0];
    exp_we    <= ~m[24];
    exp_wbyte <= d;
    exp_doe   <= 1'b1;
    chk_mask  <= m[24] ? (M_ADDR | M_WE | M_WBYTE | M_DOE) : M_WE;
    @(posedge CLK2);
    chk_mask     <= '0;
    snes_write_n <= 1'b1;
    repeat (HOLD) @(posedge CLK2);
    snes_cpu_clk  <= 1'b0;
    snes_romsel_n <= 1'b1;
    repeat (HOLD) @(posedge CLK2);
    w = mem[mem_index(m[23:1])];
    expect_equal({name, " stored byte"}, keep, m[0] ? w[7:0] : w[15:8]);
  endtask

  task automatic wait_ready(input string name);
    int n;
    n = 0;
    while (mcu_rdy !== 1'b1) begin
      @(posedge CLK2);
      n++;
      if (n > READY_LIMIT) fail_stop({name, ": mcu_rdy never came back high"});
    end
  endtask

  task automatic mcu_access(input string name, input bit wr, input rom_addr_t a,
                            input logic [7:0] d);
    mcu_addr  <= a;
    mcu_wdata <= d;
    mcu_wrq   <= wr;
    mcu_rrq   <= ~wr;
    @(posedge CLK2);
    mcu_wrq  <= 1'b0;
    mcu_rrq  <= 1'b0;
    chk_name <= name;
    exp_rdy  <= 1'b0;  // Busy right after the request
    chk_mask <= M_RDY;
    @(posedge CLK2);
    chk_mask <= '0;
    wait_ready(name);
    if (!wr) begin
      exp_mcu  <= d;
      chk_mask <= M_MCU;
      @(posedge CLK2);
      chk_mask <= '0;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    snes_addr_t a;
    snes_addr_t b;
    rom_addr_t  ma;
    logic [7:0] d;
    CLK2          = 1'b0;
    rst_n         = 1'b0;
    seed          = 32'h8a1;
    mcu_done      = 1'b0;
    chk_mask      = '0;
    chk_name      = "";
    snes_addr     = '0;
    snes_read_n   = 1'b1;
    snes_write_n  = 1'b1;
    snes_cpu_clk  = 1'b0;
    snes_romsel_n = 1'b1;
    snes_data     = '0;
    mcu_addr      = '0;
    mcu_wdata     = '0;
    mcu_rrq       = 1'b0;
    mcu_wrq       = 1'b0;
    mapper        = MAP_LOROM;
    rom_mask      = 24'h01_ffff;
    saveram_mask  = 24'h00_1fff;
    for (int i = 0; i < 131072; i++) begin
      mem[i] = fill_word({i[16], 6'b0, i[15:0]});
    end
    repeat (5) @(posedge CLK2);
    rst_n <= 1'b1;
    @(posedge CLK2);

    for (int i = 0; i < N_READS; i++) begin
      a     = $random(seed);
      a[15] = 1'b1;  // Upper half of the bank
      console_read("lorom read", a, 1'b0, 1'b1);
    end

    mapper       <= MAP_HIROM;
    rom_mask     <= 24'h00_ffff;
    saveram_mask <= 24'h00_07ff;
    @(posedge CLK2);
    console_read("hirom unmapped", 24'h00_1234, 1'b0, 1'b1);
    console_read("hirom save-ram", 24'ha0_6abd, 1'b0, 1'b1);
    for (int i = 0; i < N_READS; i++) begin
      a = $random(seed);
      console_read("hirom read", a, 1'b0, 1'b1);
    end

    mapper       <= MAP_LOROM;
    rom_mask     <= 24'h01_ffff;
    saveram_mask <= 24'h00_1fff;
    @(posedge CLK2);
    for (int i = 0; i < 3; i++) begin
      a         = $random(seed);
      a[23:20]  = 4'h7;
      a[15]     = 1'b0;
      if (a[19:17] == 3'b111) a[19] = 1'b0;  // Keep below bank 7E
      b         = $random(seed);
      b[23:15]  = 9'h003;
      d         = $random(seed);
      console_write("save-ram write", a, d);
      console_read("save-ram readback", a, 1'b0, 1'b1);
      console_write("rom area write", b, ~d);
      console_read("rom area readback", b, 1'b0, 1'b1);
    end

    repeat (DEAD_TIMEOUT + 10) @(posedge CLK2);  // Console silent, seen as dead
    for (int i = 0; i < 2; i++) begin
      ma = $random(seed);
      ma = (i == 0) ? (SAVERAM_BASE | (ma & 24'h00_07ff)) : (ma & 24'h01_ffff);
      d  = $random(seed);
      mcu_access("dead mcu write", 1'b1, ma, d);
      mcu_access("dead mcu read", 1'b0, ma, d);
    end

    for (int i = 0; i < 4; i++) begin
      a     = $random(seed);
      a[15] = 1'b1;
      console_read("live read before", a, 1'b1, 1'b1);
    end
    fork
      begin
        repeat (30) @(posedge CLK2);
        ma = $random(seed);
        ma = SAVERAM_BASE | (ma & 24'h00_1fff);
        d  = $random(seed);
        mcu_access("live mcu write", 1'b1, ma, d);
        mcu_access("live mcu read", 1'b0, ma, d);
        mcu_done = 1'b1;
      end
      begin
        while (!mcu_done) begin
          a     = $random(seed);
          a[15] = 1'b1;  // ROM only, slots come from cycle ends
          console_read("live read during", a, 1'b1, 1'b0);
        end
      end
    join
    for (int i = 0; i < 4; i++) begin
      a     = $random(seed);
      a[15] = 1'b1;
      console_read("live read after", a, 1'b1, 1'b1);
    end

    $display("*** TEST PASSED ***");
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge CLK2);
    fail_stop("watchdog expired before the test sequence finished");
  end

endmodule

//--- hdl/cart_main.sv
`timescale 1ns/1ps

module cart_main #(
  parameter logic [3:0]  ROM_CYCLE_LEN = 4'd6,
  parameter logic [17:0] DEAD_TIMEOUT  = 18'd80000,
  parameter int          ADDR_DELAY    = 6
) (
  input  logic                 CLK2,
  input  logic                 rst_n,
  // Console bus
  input  cart_pkg::snes_addr_t snes_addr,
  input  logic                 snes_read_n,
  input  logic                 snes_write_n,
  input  logic                 snes_cpu_clk,
  input  logic                 snes_romsel_n,
  input  logic [7:0]           snes_data,
  output logic [7:0]           snes_data_out,
  output logic                 snes_data_oe,
  // MCU port
  input  cart_pkg::rom_addr_t  mcu_addr,
  input  logic [7:0]           mcu_wdata,
  input  logic                 mcu_rrq,
  input  logic                 mcu_wrq,
  output logic [7:0]           mcu_rdata,
  output logic                 mcu_rdy,
  // External ROM / save-RAM
  input  logic [15:0]          rom_rdata,
  output logic [15:0]          rom_wdata,
  output logic                 rom_data_oe,
  output logic [22:0]          rom_addr,
  output logic                 rom_we,
  output logic                 rom_bhe,
  output logic                 rom_ble,
  // Cartridge configuration
  input  cart_pkg::mapper_e    mapper,
  input  cart_pkg::rom_addr_t  rom_mask,
  input  cart_pkg::rom_addr_t  saveram_mask
);
  import cart_pkg::*;

  snes_bus_if bus ();

  logic [N_STROBES-1:0] stb_pin;
  rom_addr_t            mapped_addr;
  logic                 rom_hit;
  logic                 is_rom;
  logic                 is_writable;
  logic                 rom_addr0;

  assign stb_pin[STB_READ]    = snes_read_n;
  assign stb_pin[STB_WRITE]   = snes_write_n;
  assign stb_pin[STB_CPU_CLK] = snes_cpu_clk;
  assign stb_pin[STB_ROMSEL]  = snes_romsel_n;

  ////////////////////////////////////////////////////////////////////
  // Strobe filters, one per console strobe
  ////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < N_STROBES; i++) begin : g_strobe
    logic level;
    logic fall;
    logic rise;

    snes_strobe_filter i_filter (
      .CLK2  (CLK2),
      .rst_n (rst_n),
      .pin   (stb_pin[i]),
      .level (level),
      .fall  (fall),
      .rise  (rise)
    );

    case (i)
      STB_READ: begin : g_read
        assign bus.read_n   = level;
        assign bus.rd_start = fall;
        assign bus.rd_end   = rise;
      end
      STB_WRITE: begin : g_write
        assign bus.write_n = level;
        assign bus.wr_end  = rise;
      end
      STB_CPU_CLK: begin : g_cpu_clk
        assign bus.cpu_clk     = level;
        assign bus.cycle_start = rise;
        assign bus.cycle_end   = fall;
      end
      default: begin : g_romsel
        assign bus.romsel_n = level;
      end
    endcase
  end

  snes_addr_map #(
    .ADDR_DELAY (ADDR_DELAY)
  ) i_addr_map (
    .CLK2         (CLK2),
    .rst_n        (rst_n),
    .snes_addr_in (snes_addr),
    .mapper       (mapper),
    .rom_mask     (rom_mask),
    .saveram_mask (saveram_mask),
    .mapped_addr  (mapped_addr),
    .rom_hit      (rom_hit),
    .is_rom       (is_rom),
    .is_writable  (is_writable)
  );

  rom_arbiter #(
    .ROM_CYCLE_LEN (ROM_CYCLE_LEN),
    .DEAD_TIMEOUT  (DEAD_TIMEOUT)
  ) i_rom_arbiter (
    .CLK2        (CLK2),
    .rst_n       (rst_n),
    .bus         (bus),
    .mapped_addr (mapped_addr),
    .rom_hit     (rom_hit),
    .is_writable (is_writable),
    .snes_data   (snes_data),
    .mcu_addr    (mcu_addr),
    .mcu_wdata   (mcu_wdata),
    .mcu_rrq     (mcu_rrq),
    .mcu_wrq     (mcu_wrq),
    .mcu_rdata   (mcu_rdata),
    .mcu_rdy     (mcu_rdy),
    .rom_rdata   (rom_rdata),
    .rom_addr    (rom_addr),
    .rom_addr0   (rom_addr0),
    .rom_wdata   (rom_wdata),
    .rom_data_oe (rom_data_oe),
    .rom_we      (rom_we)
  );

  // Byte lanes, active low
  assign rom_bhe = rom_addr0;
  assign rom_ble = ~rom_addr0;

  assign snes_data_out = rom_addr0 ? rom_rdata[7:0] : rom_rdata[15:8];
  assign snes_data_oe  = ~bus.read_n & ((is_rom & ~bus.romsel_n) | is_writable);

endmodule

//--- hdl/rom_arbiter.sv
`timescale 1ns/1ps

module rom_arbiter #(
  parameter logic [3:0]  ROM_CYCLE_LEN = 4'd6,
  parameter logic [17:0] DEAD_TIMEOUT  = 18'd80000
) (
  input  logic                CLK2,
  input  logic                rst_n,
  snes_bus_if.sink            bus,
  input  cart_pkg::rom_addr_t mapped_addr,
  input  logic                rom_hit,
  input  logic                is_writable,
  input  logic [7:0]          snes_data,
  input  cart_pkg::rom_addr_t mcu_addr,
  input  logic [7:0]          mcu_wdata,
  input  logic                mcu_rrq,
  input  logic                mcu_wrq,
  output logic [7:0]          mcu_rdata,
  output logic                mcu_rdy,
  input  logic [15:0]         rom_rdata,
  output logic [22:0]         rom_addr,
  output logic                rom_addr0,
  output logic [15:0]         rom_wdata,
  output logic                rom_data_oe,
  output logic                rom_we
);
  import cart_pkg::*;

  // One-hot access states
  localparam logic [4:0] ST_IDLE   = 5'b00001;
  localparam logic [4:0] ST_RD     = 5'b00010;
  localparam logic [4:0] ST_RD_END = 5'b00100;
  localparam logic [4:0] ST_WR     = 5'b01000;
  localparam logic [4:0] ST_WR_END = 5'b10000;

  logic [17:0] dead_cnt;
  logic        dead;
  logic        free_strobe;
  logic        free_slot;
  logic        rd_pend;
  logic        wr_pend;
  rom_addr_t   mcu_addr_q;
  logic [7:0]  mcu_wdata_q;
  logic [4:0]  state;
  logic [3:0]  delay;
  logic        mcu_rd_hit;
  logic        mcu_wr_hit;
  logic        mcu_hit;
  logic        access_end;
  logic        con_wr;
  logic [7:0]  wr_byte;
  logic [7:0]  rom_byte;

  ////////////////////////////////////////////////////////////////////
  // Console liveness and free bus slots
  ////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK2 or negedge rst_n) begin
    if (!rst_n) begin
      dead_cnt <= '0;
    end else if (bus.cpu_clk) begin
      dead_cnt <= '0;
    end else if (dead_cnt <= DEAD_TIMEOUT) begin
      dead_cnt <= dead_cnt + 18'd1;  // Saturates just past the timeout
    end
  end

  always_ff @(posedge CLK2 or negedge rst_n) begin
    if (!rst_n) begin
      dead <= 1'b1;
    end else if (bus.cpu_clk) begin
      dead <= 1'b0;
    end else if (dead_cnt > DEAD_TIMEOUT) begin
      dead <= 1'b1;
    end
  end

  // Console cycle that misses ROM leaves the bus idle
  always_ff @(posedge CLK2 or negedge rst_n) begin
    if (!rst_n) begin
      free_strobe <= 1'b0;
    end else begin
      free_strobe <= bus.cycle_start & ~rom_hit;
    end
  end

  assign free_slot = bus.cycle_end | free_strobe | dead;

  ////////////////////////////////////////////////////////////////////
  // MCU request handshake
  ////////////////////////////////////////////////////////////////////

  assign access_end = |(state & (ST_RD_END | ST_WR_END));

  always_ff @(posedge CLK2 or negedge rst_n) begin
    if (!rst_n) begin
      rd_pend <= 1'b0;
      wr_pend <= 1'b0;
      mcu_rdy <= 1'b1;
    end else if (mcu_rdy && mcu_rrq) begin
      rd_pend <= 1'b1;
      mcu_rdy <= 1'b0;
    end else if (mcu_rdy && mcu_wrq) begin
      wr_pend <= 1'b1;
      mcu_rdy <= 1'b0;
    end else if (access_end) begin
      rd_pend <= 1'b0;
      wr_pend <= 1'b0;
      mcu_rdy <= 1'b1;
    end
  end

  always_ff @(posedge CLK2) begin
    if (mcu_rdy && (mcu_rrq || mcu_wrq)) begin
      mcu_addr_q  <= mcu_addr;
      mcu_wdata_q <= mcu_wdata;
    end
  end

  always_ff @(posedge CLK2 or negedge rst_n) begin
    if (!rst_n) begin
      state <= ST_IDLE;
      delay <= '0;
    end else if (dead && bus.cpu_clk) begin
      state <= ST_IDLE;  // Console woke up, pending access starts over
    end else begin
      case (state)
        ST_IDLE: begin
          if (free_slot && rd_pend) begin
            state <= ST_RD;
            delay <= ROM_CYCLE_LEN;
          end else if (free_slot && wr_pend) begin
            state <= ST_WR;
            delay <= ROM_CYCLE_LEN;
          end
        end
        ST_RD, ST_WR: begin
          delay <= delay - 4'd1;
          if (delay == 4'd0) begin
            state <= (state == ST_RD) ? ST_RD_END : ST_WR_END;
          end
        end
        default: state <= ST_IDLE;  // End states last one cycle
      endcase
    end
  end

  assign mcu_rd_hit = |(state & ST_RD);
  assign mcu_wr_hit = |(state & ST_WR);
  assign mcu_hit    = mcu_rd_hit | mcu_wr_hit;

  assign rom_byte = rom_addr0 ? rom_rdata[7:0] : rom_rdata[15:8];

  always_ff @(posedge CLK2) begin
    if (mcu_rd_hit) begin
      mcu_rdata <= rom_byte;  // Last sample before RD_END wins
    end
  end

  ////////////////////////////////////////////////////////////////////
  // ROM bus muxing
  ////////////////////////////////////////////////////////////////////

  assign rom_addr  = mcu_hit ? mcu_addr_q[23:1] : mapped_addr[23:1];
  assign rom_addr0 = mcu_hit ? mcu_addr_q[0] : mapped_addr[0];

  assign con_wr      = rom_hit & ~bus.write_n;
  assign wr_byte     = con_wr ? snes_data : mcu_wdata_q;
  assign rom_wdata   = rom_addr0 ? {8'h00, wr_byte} : {wr_byte, 8'h00};
  assign rom_data_oe = con_wr | mcu_wr_hit;

  // Console save-RAM write has priority, else MCU write pulls low
  assign rom_we = (rom_hit & is_writable & bus.cpu_clk) ? bus.write_n : ~mcu_wr_hit;

endmodule

//--- hdl/snes_addr_map.sv
`timescale 1ns/1ps

module snes_addr_map #(
  parameter int ADDR_DELAY = 6
) (
  input  logic                 CLK2,
  input  logic                 rst_n,
  input  cart_pkg::snes_addr_t snes_addr_in,
  input  cart_pkg::mapper_e    mapper,
  input  cart_pkg::rom_addr_t  rom_mask,
  input  cart_pkg::rom_addr_t  saveram_mask,
  output cart_pkg::rom_addr_t  mapped_addr,
  output logic                 rom_hit,
  output logic                 is_rom,
  output logic                 is_writable
);
  import cart_pkg::*;

  snes_addr_t addr_dly [ADDR_DELAY];
  snes_addr_u addr;

  rom_addr_t  lo_rom_addr;
  rom_addr_t  lo_sram_addr;
  rom_addr_t  hi_rom_addr;
  rom_addr_t  hi_sram_addr;
  logic       lo_is_rom;
  logic       lo_is_sram;
  logic       hi_is_rom;
  logic       hi_is_sram;
  rom_addr_t  sel_addr;
  logic       sel_rom;
  logic       sel_sram;

  // Address pipeline, keeps the decode in step with the strobe filters
  always_ff @(posedge CLK2 or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < ADDR_DELAY; i++) begin
        addr_dly[i] <= '0;
      end
    end else begin
      addr_dly[0] <= snes_addr_in;
      for (int i = 1; i < ADDR_DELAY; i++) begin
        addr_dly[i] <= addr_dly[i-1];
      end
    end
  end

  assign addr = addr_dly[ADDR_DELAY-1] & addr_dly[ADDR_DELAY-2];  // Glitch filter

  ////////////////////////////////////////////////////////////////////
  // Bank layout decode
  ////////////////////////////////////////////////////////////////////

  // LoROM, banks 7E/7F belong to work RAM
  assign lo_is_rom    = addr.lorom.page && (addr.lorom.bank[7:1] != 7'b0111111);
  assign lo_rom_addr  = {2'b00, addr.lorom.bank[6:0], addr.lorom.offset} & rom_mask;
  assign lo_is_sram   = !addr.lorom.page && (addr.lorom.bank[7:4] == 4'h7)
                        && (addr.lorom.bank[3:1] != 3'b111);          // Banks 70-7D
  assign lo_sram_addr = SAVERAM_BASE
                        + ({5'b0, addr.lorom.bank[3:0], addr.lorom.offset} & saveram_mask);

  // HiROM
  assign hi_is_rom    = addr.hirom.bank[6] | addr.hirom.offset[15];
  assign hi_rom_addr  = {2'b00, addr.hirom.bank[5:0], addr.hirom.offset} & rom_mask;
  assign hi_is_sram   = (addr.hirom.bank[6:5] == 2'b01)
                        && (addr.hirom.offset[15:13] == 3'b011);    // 20-3F:6000-7FFF
  assign hi_sram_addr = SAVERAM_BASE
                        + ({6'b0, addr.hirom.bank[4:0], addr.hirom.offset[12:0]} & saveram_mask);

  always_comb begin
    if (mapper == MAP_HIROM) begin
      sel_rom  = hi_is_rom;
      sel_sram = hi_is_sram;
      sel_addr = hi_is_sram ? hi_sram_addr : hi_rom_addr;
    end else begin
      sel_rom  = lo_is_rom;
      sel_sram = lo_is_sram;
      sel_addr = lo_is_sram ? lo_sram_addr : lo_rom_addr;
    end
  end

  always_ff @(posedge CLK2 or negedge rst_n) begin
    if (!rst_n) begin
      mapped_addr <= '0;
      is_rom      <= 1'b0;
      is_writable <= 1'b0;
    end else begin
      mapped_addr <= sel_addr;
      is_rom      <= sel_rom;
      is_writable <= sel_sram;
    end
  end

  assign rom_hit = is_rom | is_writable;

endmodule

//--- hdl/snes_strobe_filter.sv
`timescale 1ns/1ps

module snes_strobe_filter (
  input  logic CLK2,
  input  logic rst_n,
  input  logic pin,
  output logic level,
  output logic fall,
  output logic rise
);

  // Newest sample in bit 0
  logic [5:0] hist;

  always_ff @(posedge CLK2 or negedge rst_n) begin
    if (!rst_n) begin
      hist <= 6'b111111;  // Strobes idle high
    end else begin
      hist <= {hist[4:0], pin};
    end
  end

  // Two samples ANDed, rejects single cycle highs
  assign level = hist[2] & hist[1];

  // Two old samples then four new ones, fires exactly once per edge
  assign fall = (hist == 6'b110000);
  assign rise = (hist == 6'b001111);

endmodule

//--- hdl/snes_bus_if.sv
`timescale 1ns/1ps

interface snes_bus_if;
  // Filtered levels, active low except the CPU clock
  logic read_n;
  logic write_n;
  logic cpu_clk;
  logic romsel_n;

  // Single cycle edge pulses
  logic rd_start;
  logic rd_end;
  logic wr_end;
  logic cycle_start;  // CPU clock rising
  logic cycle_end;    // CPU clock falling

  modport filter (
    output read_n, write_n, cpu_clk, romsel_n,
    output rd_start, rd_end, wr_end, cycle_start, cycle_end
  );

  modport sink (
    input read_n, write_n, cpu_clk, romsel_n,
    input rd_start, rd_end, wr_end, cycle_start, cycle_end
  );

endinterface

//--- hdl/cart_pkg.sv
package cart_pkg;

  ////////////////////////////////////////////////////////////////////
  // Address types
  ////////////////////////////////////////////////////////////////////

  typedef logic [23:0] snes_addr_t;  // Console bus address
  typedef logic [23:0] rom_addr_t;   // External byte address, bit 0 picks the byte

  // 32 KiB bank layout, upper half of each bank is ROM
  typedef struct packed {
    logic [7:0]  bank;
    logic        page;
    logic [14:0] offset;
  } lorom_view_t;

  // 64 KiB bank layout
  typedef struct packed {
    logic [7:0]  bank;
    logic [15:0] offset;
  } hirom_view_t;

  // Same console word, read through either bank layout
  typedef union packed {
    lorom_view_t lorom;
    hirom_view_t hirom;
  } snes_addr_u;

  typedef enum logic {
    MAP_LOROM = 1'b0,
    MAP_HIROM = 1'b1
  } mapper_e;

  // Save-RAM window in external memory
  localparam rom_addr_t SAVERAM_BASE = 24'hE0_0000;

  ////////////////////////////////////////////////////////////////////
  // Console strobe slots
  ////////////////////////////////////////////////////////////////////

  localparam int N_STROBES = 4;

  typedef enum logic [1:0] {
    STB_READ    = 2'd0,
    STB_WRITE   = 2'd1,
    STB_CPU_CLK = 2'd2,
    STB_ROMSEL  = 2'd3
  } strobe_idx_e;

endpackage
